/* loopback_settings.svh */
`ifndef LOOPBACK_SETTINGS_SVH
`define LOOPBACK_SETTINGS_SVH

// Sample and soft value widths
`define SAMP_W 16
`define SOFT_W 24

// MRR cycle framing in input samples
`define SAMPLES_PER_CYCLE 4
`define SAMPLES_PER_CYCLE_LOG2 2

// Cycle positions of the energy windows inside a received bit
`define ZERO_CYCLE 3
`define ONE_CYCLE 5

// PN code with the first chip in the MSB
`define PN_SEQ 15'b000100110101111
`define PN_LEN 15
`define SEARCH_SPAN 8
`define SEARCH_SPAN_LOG2 3
`define STORE_BITS (`PN_LEN + `SEARCH_SPAN)

// Transmit and holdoff lengths
`define TX_BITS 32
`define TX_SYMBOL_CYCLES 5
`define HOLDOFF_CYCLES 16

// Decoded output stream
`define QUEUE_DEPTH 16
`define INIT_CREDITS 4
`define META_WORDS 4

`endif

/* loopback_pkg.sv */
`default_nettype none

package loopback_pkg;

    // Main sequencer
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RX,
        ST_TURNAROUND,
        ST_TX,
        ST_HOLDOFF,
        ST_METADATA
    } loop_state_t;

    // PN offset search
    typedef enum logic [2:0] {
        SR_IDLE,
        SR_ACCUM,
        SR_DRAIN,
        SR_COMPARE,
        SR_DONE
    } search_state_t;

    // Metadata words in send order
    typedef enum logic [1:0] {
        META_CFO,
        META_TIME_HI,
        META_TIME_LO,
        META_PN_OFFSET
    } meta_sel_t;

endpackage

`default_nettype wire

/* cycle_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loopback_settings.svh"

module cycle_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_sample_valid,
    input  logic        i_clear,
    input  logic        i_tx_mode,
    input  logic [7:0]  i_recharge_len,
    output logic        o_cycle_end,
    output logic        o_bit_end,
    output logic [7:0]  o_cycle_pos,
    output logic [15:0] o_free_count
);

    logic [`SAMPLES_PER_CYCLE_LOG2-1:0] samp_cnt;
    logic [8:0]                         last_pos;

    // A received bit spans recharge_len + 3 cycles, a TX symbol a fixed count
    assign last_pos = i_tx_mode ? 9'(`TX_SYMBOL_CYCLES - 1) : {1'b0, i_recharge_len} + 9'd2;

    assign o_cycle_end = i_sample_valid && (samp_cnt == `SAMPLES_PER_CYCLE - 1);
    assign o_bit_end   = o_cycle_end && ({1'b0, o_cycle_pos} == last_pos);

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            samp_cnt     <= '0;
            o_cycle_pos  <= 8'd0;
            o_free_count <= 16'd0;
        end else if (i_sample_valid) begin
            samp_cnt <= o_cycle_end ? '0 : samp_cnt + 1'b1;
            if (o_cycle_end) begin
                o_free_count <= o_free_count + 16'd1;
                o_cycle_pos  <= o_bit_end ? 8'd0 : o_cycle_pos + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* bit_energy.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loopback_settings.svh"

module bit_energy (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_sample_valid,
    input  logic [`SAMP_W-1:0]        i_sample,
    input  logic [7:0]                i_cycle_pos,
    input  logic                      i_bit_end,
    input  logic                      i_enable,
    output logic signed [`SOFT_W-1:0] o_soft_value,
    output logic                      o_soft_valid
);

    localparam int ACC_W = `SAMP_W + `SAMPLES_PER_CYCLE_LOG2;

    logic [ACC_W-1:0]         zero_acc;
    logic [ACC_W-1:0]         one_acc;
    logic [ACC_W-1:0]         zero_next;
    logic [ACC_W-1:0]         one_next;
    logic                     take;
    logic signed [`SOFT_W-1:0] zero_ext;
    logic signed [`SOFT_W-1:0] one_ext;

    assign take = i_enable && i_sample_valid;

    // Running sums including the current sample
    assign zero_next = zero_acc + ((take && i_cycle_pos == `ZERO_CYCLE) ? ACC_W'(i_sample) : '0);
    assign one_next  = one_acc + ((take && i_cycle_pos == `ONE_CYCLE) ? ACC_W'(i_sample) : '0);

    assign zero_ext = `SOFT_W'(zero_next);
    assign one_ext  = `SOFT_W'(one_next);

    // Positive soft value means energy in the zero window
    assign o_soft_value = zero_ext - one_ext;
    assign o_soft_valid = i_enable && i_bit_end;

    always_ff @(posedge clk) begin
        if (rst || !i_enable || i_bit_end) begin
            zero_acc <= '0;
            one_acc  <= '0;
        end else begin
            zero_acc <= zero_next;
            one_acc  <= one_next;
        end
    end

endmodule

`default_nettype wire

/* pn_search.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loopback_settings.svh"

module pn_search (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_clear,
    input  logic signed [`SOFT_W-1:0]    i_soft_value,
    input  logic                         i_soft_valid,
    output logic                         o_search_done,
    output logic [`SEARCH_SPAN_LOG2-1:0] o_pn_offset
);

    import loopback_pkg::*;

    localparam int CORR_W = `SOFT_W + 4;
    localparam int ADDR_W = $clog2(`STORE_BITS + 1);
    localparam logic [`PN_LEN-1:0] PN_CODE = `PN_SEQ;

    search_state_t               state;
    logic signed [`SOFT_W-1:0]   mem [`STORE_BITS];
    logic signed [`SOFT_W-1:0]   rd_data;
    logic [ADDR_W-1:0]           wr_addr;
    logic [ADDR_W-1:0]           rd_addr;
    logic                        store;
    logic [`SEARCH_SPAN_LOG2-1:0] offset;
    logic [$clog2(`PN_LEN)-1:0]  chip;
    logic                        acc_en;
    logic                        chip_bit;
    logic signed [CORR_W-1:0]    corr;
    logic signed [CORR_W-1:0]    best_corr;

    assign store   = i_soft_valid && (wr_addr < `STORE_BITS);
    assign rd_addr = ADDR_W'(offset) + ADDR_W'(chip);

    // Soft value store with read data one clock after the address
    always_ff @(posedge clk) begin
        if (store) begin
            mem[wr_addr] <= i_soft_value;
        end
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SR_IDLE;
            wr_addr     <= '0;
            offset      <= '0;
            chip        <= '0;
            acc_en      <= 1'b0;
            chip_bit    <= 1'b0;
            corr        <= '0;
            best_corr   <= '0;
            o_pn_offset <= '0;
        end else begin
            // Chip sign travels alongside the memory read
            acc_en   <= (state == SR_ACCUM);
            chip_bit <= PN_CODE[`PN_LEN - 1 - chip];
            if (acc_en) begin
                corr <= chip_bit ? corr - CORR_W'(rd_data) : corr + CORR_W'(rd_data);
            end
            if (store) begin
                wr_addr <= wr_addr + 1'b1;
            end

            case (state)
                SR_IDLE: begin
                    if (wr_addr == `STORE_BITS) begin
                        state       <= SR_ACCUM;
                        offset      <= '0;
                        chip        <= '0;
                        corr        <= '0;
                        best_corr   <= '0;
                        o_pn_offset <= '0;
                    end
                end
                SR_ACCUM: begin
                    if (chip == `PN_LEN - 1) begin
                        chip  <= '0;
                        state <= SR_DRAIN;
                    end else begin
                        chip <= chip + 1'b1;
                    end
                end
                SR_DRAIN: state <= SR_COMPARE;
                SR_COMPARE: begin
                    // Strict compare keeps the earliest offset on a tie
                    if (corr > best_corr) begin
                        best_corr   <= corr;
                        o_pn_offset <= offset;
                    end
                    corr   <= '0;
                    offset <= offset + 1'b1;
                    state  <= (offset == `SEARCH_SPAN - 1) ? SR_DONE : SR_ACCUM;
                end
                default: ;
            endcase

            // New trigger restarts storage and search
            if (i_clear) begin
                state   <= SR_IDLE;
                wr_addr <= '0;
            end
        end
    end

    assign o_search_done = (state == SR_DONE);

endmodule

`default_nettype wire

/* decoded_out.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loopback_settings.svh"

module decoded_out (
    input  logic                         clk,
    input  logic                         rst,
    input  logic signed [`SOFT_W-1:0]    i_soft_value,
    input  logic                         i_soft_valid,
    input  logic                         i_meta_push,
    input  loopback_pkg::meta_sel_t      i_meta_sel,
    input  logic [31:0]                  i_cfo_idx,
    input  logic [63:0]                  i_cur_time,
    input  logic [`SEARCH_SPAN_LOG2-1:0] i_pn_offset,
    input  logic                         i_decoded_credit,
    output logic [31:0]                  o_decoded_data,
    output logic                         o_decoded_valid,
    output logic                         o_decoded_last,
    output logic                         o_overflow
);

    import loopback_pkg::*;

    localparam int PTR_W  = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W  = $clog2(`QUEUE_DEPTH + 1);
    localparam int CRED_W = $clog2(`INIT_CREDITS + 1);

    logic [32:0]       queue [`QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic [31:0]       meta_word;
    logic [31:0]       push_data;
    logic              push;
    logic              push_ok;
    logic              pop;

    always_comb begin
        case (i_meta_sel)
            META_CFO:     meta_word = i_cfo_idx;
            META_TIME_HI: meta_word = i_cur_time[63:32];
            META_TIME_LO: meta_word = i_cur_time[31:0];
            default:      meta_word = 32'(i_pn_offset);
        endcase
    end

    assign push_data = i_meta_push ? meta_word
                                   : {{(32 - `SOFT_W){i_soft_value[`SOFT_W-1]}}, i_soft_value};
    assign push    = i_meta_push || i_soft_valid;
    assign push_ok = push && (count != `QUEUE_DEPTH);
    // One word per clock while the consumer has room
    assign pop     = (count != 0) && (credits != 0);

    always_ff @(posedge clk) begin
        if (push_ok) begin
            queue[wr_ptr] <= {i_meta_push && (i_meta_sel == META_PN_OFFSET), push_data};
        end
        if (pop) begin
            o_decoded_data <= queue[rd_ptr][31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            credits         <= CRED_W'(`INIT_CREDITS);
            o_decoded_valid <= 1'b0;
            o_decoded_last  <= 1'b0;
            o_overflow      <= 1'b0;
        end else begin
            wr_ptr          <= wr_ptr + PTR_W'(push_ok);
            rd_ptr          <= rd_ptr + PTR_W'(pop);
            count           <= count + CNT_W'(push_ok) - CNT_W'(pop);
            credits         <= credits - CRED_W'(pop) + CRED_W'(i_decoded_credit);
            o_decoded_valid <= pop;
            o_decoded_last  <= pop && queue[rd_ptr][32];
            // Sticky until reset
            if (push && !push_ok) begin
                o_overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* loopback_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loopback_settings.svh"

module loopback_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_fm_flag,
    input  logic                         i_tx_disable,
    input  logic [31:0]                  i_tx_word,
    input  logic [7:0]                   i_num_payload_bits,
    input  logic [15:0]                  i_wait_step,
    input  logic                         i_cycle_end,
    input  logic                         i_bit_end,
    input  logic [7:0]                   i_cycle_pos,
    input  logic [15:0]                  i_free_count,
    input  logic                         i_search_done,
    input  logic [`SEARCH_SPAN_LOG2-1:0] i_pn_offset,
    output logic                         o_timer_clear,
    output logic                         o_tx_mode,
    output logic                         o_energy_en,
    output logic                         o_search_clear,
    output logic                         o_meta_push,
    output loopback_pkg::meta_sel_t      o_meta_sel,
    output logic                         o_busy,
    output logic                         o_tx_en,
    output logic                         o_tx_pulse,
    output logic                         o_detector_reset
);

    import loopback_pkg::*;

    loop_state_t state;
    loop_state_t next_state;
    logic [8:0]  rx_bits;
    logic [8:0]  rx_target;
    logic [4:0]  tx_bits;
    logic [1:0]  meta_idx;
    logic        cur_bit;

    // Code start plus code plus payload
    assign rx_target = 9'(i_pn_offset) + 9'(`PN_LEN) + 9'(i_num_payload_bits);
    assign cur_bit   = i_tx_word[tx_bits];

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: if (i_fm_flag) next_state = ST_RX;
            ST_RX: begin
                if (i_search_done && rx_bits >= rx_target) begin
                    next_state = ST_TURNAROUND;
                end
            end
            ST_TURNAROUND: begin
                if (i_wait_step == 16'd0
                    || (i_cycle_end && i_free_count == i_wait_step - 16'd1)) begin
                    next_state = ST_TX;
                end
            end
            ST_TX: begin
                if (i_bit_end && tx_bits == 5'(`TX_BITS - 1)) next_state = ST_HOLDOFF;
            end
            ST_HOLDOFF: begin
                if (i_cycle_end && i_free_count == `HOLDOFF_CYCLES - 1) begin
                    next_state = ST_METADATA;
                end
            end
            ST_METADATA: if (meta_idx == 2'(`META_WORDS - 1)) next_state = ST_IDLE;
            default: next_state = ST_IDLE;
        endcase
    end

    // Timer restarts at each phase change and stays cleared while idle
    assign o_timer_clear  = (state == ST_IDLE) || (state == ST_METADATA) || (next_state != state);
    assign o_tx_mode      = (state == ST_TX);
    assign o_energy_en    = (state == ST_RX);
    assign o_search_clear = (state == ST_IDLE) && i_fm_flag;
    assign o_meta_push    = (state == ST_METADATA);
    assign o_meta_sel     = meta_sel_t'(meta_idx);
    assign o_busy         = (state != ST_IDLE);
    assign o_tx_en        = (state == ST_TX) && !i_tx_disable;
    // Early pulse for a 1 and late pulse for a 0
    assign o_tx_pulse     = o_tx_en && (cur_bit ? (i_cycle_pos == 8'd0) : (i_cycle_pos == 8'd2));
    assign o_detector_reset = (state == ST_TX) || (state == ST_HOLDOFF);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            rx_bits  <= 9'd0;
            tx_bits  <= 5'd0;
            meta_idx <= 2'd0;
        end else begin
            state <= next_state;
            if (state == ST_IDLE) begin
                rx_bits  <= 9'd0;
                tx_bits  <= 5'd0;
                meta_idx <= 2'd0;
            end
            if (state == ST_RX && i_bit_end) begin
                rx_bits <= rx_bits + 9'd1;
            end
            if (state == ST_TX && i_bit_end) begin
                tx_bits <= tx_bits + 5'd1;
            end
            if (state == ST_METADATA) begin
                meta_idx <= meta_idx + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* mrr_loopback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loopback_settings.svh"

module mrr_loopback (
    input  logic               clk,
    input  logic               rst,
    input  logic [`SAMP_W-1:0] i_sample,
    input  logic               i_sample_valid,
    input  logic               i_fm_flag,
    input  logic               i_tx_disable,
    input  logic [31:0]        i_tx_word,
    input  logic [7:0]         i_num_payload_bits,
    input  logic [15:0]        i_wait_step,
    input  logic [7:0]         i_recharge_len,
    input  logic [31:0]        i_cfo_idx,
    input  logic [63:0]        i_cur_time,
    input  logic               i_decoded_credit,
    output logic               o_busy,
    output logic               o_tx_en,
    output logic               o_tx_pulse,
    output logic               o_detector_reset,
    output logic [31:0]        o_decoded_data,
    output logic               o_decoded_valid,
    output logic               o_decoded_last,
    output logic               o_overflow
);

    import loopback_pkg::*;

    logic                         cycle_end;
    logic                         bit_end;
    logic [7:0]                   cycle_pos;
    logic [15:0]                  free_count;
    logic                         timer_clear;
    logic                         tx_mode;
    logic                         energy_en;
    logic signed [`SOFT_W-1:0]    soft_value;
    logic                         soft_valid;
    logic                         search_clear;
    logic                         search_done;
    logic [`SEARCH_SPAN_LOG2-1:0] pn_offset;
    logic                         meta_push;
    meta_sel_t                    meta_sel;

    cycle_timer cycle_timer_inst (
        .clk            (clk),
        .rst            (rst),
        .i_sample_valid (i_sample_valid),
        .i_clear        (timer_clear),
        .i_tx_mode      (tx_mode),
        .i_recharge_len (i_recharge_len),
        .o_cycle_end    (cycle_end),
        .o_bit_end      (bit_end),
        .o_cycle_pos    (cycle_pos),
        .o_free_count   (free_count)
    );

    bit_energy bit_energy_inst (
        .clk            (clk),
        .rst            (rst),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_cycle_pos    (cycle_pos),
        .i_bit_end      (bit_end),
        .i_enable       (energy_en),
        .o_soft_value   (soft_value),
        .o_soft_valid   (soft_valid)
    );

    pn_search pn_search_inst (
        .clk           (clk),
        .rst           (rst),
        .i_clear       (search_clear),
        .i_soft_value  (soft_value),
        .i_soft_valid  (soft_valid),
        .o_search_done (search_done),
        .o_pn_offset   (pn_offset)
    );

    decoded_out decoded_out_inst (
        .clk              (clk),
        .rst              (rst),
        .i_soft_value     (soft_value),
        .i_soft_valid     (soft_valid),
        .i_meta_push      (meta_push),
        .i_meta_sel       (meta_sel),
        .i_cfo_idx        (i_cfo_idx),
        .i_cur_time       (i_cur_time),
        .i_pn_offset      (pn_offset),
        .i_decoded_credit (i_decoded_credit),
        .o_decoded_data   (o_decoded_data),
        .o_decoded_valid  (o_decoded_valid),
        .o_decoded_last   (o_decoded_last),
        .o_overflow       (o_overflow)
    );

    loopback_ctrl loopback_ctrl_inst (
        .clk                (clk),
        .rst                (rst),
        .i_fm_flag          (i_fm_flag),
        .i_tx_disable       (i_tx_disable),
        .i_tx_word          (i_tx_word),
        .i_num_payload_bits (i_num_payload_bits),
        .i_wait_step        (i_wait_step),
        .i_cycle_end        (cycle_end),
        .i_bit_end          (bit_end),
        .i_cycle_pos        (cycle_pos),
        .i_free_count       (free_count),
        .i_search_done      (search_done),
        .i_pn_offset        (pn_offset),
        .o_timer_clear      (timer_clear),
        .o_tx_mode          (tx_mode),
        .o_energy_en        (energy_en),
        .o_search_clear     (search_clear),
        .o_meta_push        (meta_push),
        .o_meta_sel         (meta_sel),
        .o_busy             (o_busy),
        .o_tx_en            (o_tx_en),
        .o_tx_pulse         (o_tx_pulse),
        .o_detector_reset   (o_detector_reset)
    );

endmodule

`default_nettype wire

/* tb_mrr_loopback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loopback_settings.svh"

module tb_mrr_loopback;

    localparam int RECHARGE   = 40;
    localparam int CYCLE_LEN  = RECHARGE + 3;
    localparam int SPC        = `SAMPLES_PER_CYCLE;
    localparam int WAIT_STEP  = 8;
    localparam int SYM_CLOCKS = `TX_SYMBOL_CYCLES * SPC;
    localparam int HIGH_LEVEL = 1000;
    localparam int BIG_LIMIT  = 1 << 30;
    localparam int STALL_BITS = 10;
    localparam logic [`PN_LEN-1:0] PN_CODE = `PN_SEQ;
    localparam logic [31:0] CFO_IDX  = 32'h1234_5678;
    localparam logic [63:0] CUR_TIME = 64'h0123_4567_89ab_cdef;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic [`SAMP_W-1:0] i_sample = '0;
    logic               i_sample_valid = 1'b0;
    logic               i_fm_flag = 1'b0;
    logic               i_tx_disable = 1'b0;
    logic [31:0]        i_tx_word = 32'ha5c3_0f96;
    logic [7:0]         i_num_payload_bits = 8'd6;
    logic [15:0]        i_wait_step = 16'(WAIT_STEP);
    logic [7:0]         i_recharge_len = 8'(RECHARGE);
    logic [31:0]        i_cfo_idx = CFO_IDX;
    logic [63:0]        i_cur_time = CUR_TIME;
    logic               i_decoded_credit = 1'b0;
    logic               o_busy;
    logic               o_tx_en;
    logic               o_tx_pulse;
    logic               o_detector_reset;
    logic [31:0]        o_decoded_data;
    logic               o_decoded_valid;
    logic               o_decoded_last;
    logic               o_overflow;

    int          seed = 32'he785;
    logic [31:0] got_data [$];
    logic        got_last [$];
    int          exp_soft [$];
    int          word_count = 0;
    int          credit_sent = 0;
    int          credit_limit = BIG_LIMIT;
    int          tx_clock = 0;
    int          pulse_count = 0;
    int          bad_pulse = 0;
    int          det_clocks = 0;
    int          tx_en_clocks = 0;
    logic        prev_pulse = 1'b0;
    logic [31:0] tx_seen = '0;

    mrr_loopback mrr_loopback_inst (
        .clk                (clk),
        .rst                (rst),
        .i_sample           (i_sample),
        .i_sample_valid     (i_sample_valid),
        .i_fm_flag          (i_fm_flag),
        .i_tx_disable       (i_tx_disable),
        .i_tx_word          (i_tx_word),
        .i_num_payload_bits (i_num_payload_bits),
        .i_wait_step        (i_wait_step),
        .i_recharge_len     (i_recharge_len),
        .i_cfo_idx          (i_cfo_idx),
        .i_cur_time         (i_cur_time),
        .i_decoded_credit   (i_decoded_credit),
        .o_busy             (o_busy),
        .o_tx_en            (o_tx_en),
        .o_tx_pulse         (o_tx_pulse),
        .o_detector_reset   (o_detector_reset),
        .o_decoded_data     (o_decoded_data),
        .o_decoded_valid    (o_decoded_valid),
        .o_decoded_last     (o_decoded_last),
        .o_overflow         (o_overflow)
    );

    always #5 clk = ~clk;

    // Consumer collects words, hands back one credit per word and decodes TX pulses
    always @(negedge clk) begin
        int sym;
        int cyc;
        if (o_decoded_valid) begin
            got_data.push_back(o_decoded_data);
            got_last.push_back(o_decoded_last);
            word_count++;
        end
        if (credit_sent < word_count && credit_sent < credit_limit) begin
            i_decoded_credit = 1'b1;
            credit_sent++;
        end else begin
            i_decoded_credit = 1'b0;
        end
        if (o_detector_reset) begin
            det_clocks++;
        end
        if (o_tx_pulse && !o_tx_en) begin
            bad_pulse++;
        end
        if (o_tx_en) begin
            if (!o_detector_reset) begin
                bad_pulse++;
            end
            if (tx_clock == 0) begin
                tx_seen = '0;
            end
            sym = tx_clock / SYM_CLOCKS;
            cyc = (tx_clock % SYM_CLOCKS) / SPC;
            if (o_tx_pulse && !prev_pulse) begin
                pulse_count++;
                if (cyc == 0) begin
                    tx_seen = tx_seen | (32'd1 << sym);
                end else if (cyc != 2) begin
                    bad_pulse++;
                end
            end
            tx_en_clocks++;
            tx_clock++;
        end else begin
            tx_clock = 0;
        end
        prev_pulse = o_tx_pulse;
    end

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("** Error %s expected 0x%0h actual 0x%0h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic logic pn_chip(input int j);
        logic [`PN_LEN-1:0] shifted;
        shifted = PN_CODE >> (`PN_LEN - 1 - j);
        return shifted[0];
    endfunction

    // Filler ones before the code, alternating payload after it
    function automatic logic bit_at(input int b);
        if (b < 3) begin
            return 1'b1;
        end
        if (b < 3 + `PN_LEN) begin
            return pn_chip(b - 3);
        end
        return 1'((b - 3 - `PN_LEN) % 2);
    endfunction

    // Best code start from the model soft values with the earliest winning a tie
    function automatic int model_offset();
        int best;
        int best_k;
        int corr;
        best = 0;
        best_k = 0;
        for (int k = 0; k < `SEARCH_SPAN; k++) begin
            corr = 0;
            for (int j = 0; j < `PN_LEN; j++) begin
                corr = pn_chip(j) ? corr - exp_soft[k + j] : corr + exp_soft[k + j];
            end
            if (corr > best) begin
                best = corr;
                best_k = k;
            end
        end
        return best_k;
    endfunction

    function automatic int packet_clocks(input int npay);
        return (3 + `PN_LEN + npay) * CYCLE_LEN * SPC + WAIT_STEP * SPC
               + `TX_BITS * SYM_CLOCKS + `HOLDOFF_CYCLES * SPC + 200;
    endfunction

    task automatic next_noise(output int n);
        n = $random(seed) & 15;
    endtask

    // Trigger, play one packet and model its soft values, then idle until done
    task automatic run_packet(input int npay);
        int nbits;
        int smp;
        int zsum;
        int osum;
        logic bitv;
        nbits = 3 + `PN_LEN + npay;
        i_num_payload_bits = 8'(npay);
        exp_soft.delete();
        @(negedge clk);
        i_fm_flag = 1'b1;
        @(negedge clk);
        i_fm_flag = 1'b0;
        check_value("busy_rise", 64'd1, 64'(o_busy));
        for (int b = 0; b < nbits; b++) begin
            bitv = bit_at(b);
            zsum = 0;
            osum = 0;
            for (int c = 0; c < CYCLE_LEN; c++) begin
                for (int s = 0; s < SPC; s++) begin
                    next_noise(smp);
                    if ((c == `ZERO_CYCLE && !bitv) || (c == `ONE_CYCLE && bitv)) begin
                        smp = smp + HIGH_LEVEL;
                    end
                    if (c == `ZERO_CYCLE) zsum = zsum + smp;
                    if (c == `ONE_CYCLE) osum = osum + smp;
                    i_sample = 16'(smp);
                    @(negedge clk);
                end
            end
            exp_soft.push_back(zsum - osum);
        end
        while (o_busy) begin
            next_noise(smp);
            i_sample = 16'(smp);
            @(negedge clk);
        end
    endtask

    task automatic wait_words(input int target);
        while (word_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic verify_packet(input string name, input int base);
        int nsoft;
        nsoft = exp_soft.size();
        for (int i = 0; i < nsoft; i++) begin
            check_value({name, "_soft"}, 64'($unsigned(exp_soft[i])), 64'(got_data[base + i]));
            check_value({name, "_soft_last"}, 64'd0, 64'(got_last[base + i]));
        end
        check_value({name, "_cfo"}, 64'(CFO_IDX), 64'(got_data[base + nsoft]));
        check_value({name, "_time_hi"}, 64'(CUR_TIME[63:32]), 64'(got_data[base + nsoft + 1]));
        check_value({name, "_time_lo"}, 64'(CUR_TIME[31:0]), 64'(got_data[base + nsoft + 2]));
        check_value({name, "_pn_offset"}, 64'd3, 64'(got_data[base + nsoft + 3]));
        check_value({name, "_pn_model"}, 64'(model_offset()), 64'(got_data[base + nsoft + 3]));
        for (int i = 0; i < `META_WORDS; i++) begin
            check_value({name, "_meta_last"}, 64'(i == `META_WORDS - 1),
                        64'(got_last[base + nsoft + i]));
        end
    endtask

    task automatic idle_after_reset();
        repeat (50) begin
            @(negedge clk);
            check_value("reset_idle", 64'd0, 64'({o_busy, o_tx_en, o_tx_pulse,
                        o_detector_reset, o_decoded_valid, o_overflow}));
        end
        check_value("reset_idle_words", 64'd0, 64'(word_count));
    endtask

    task automatic full_receive();
        int base;
        base = word_count;
        run_packet(6);
        wait_words(base + 3 + `PN_LEN + 6 + `META_WORDS);
        repeat (20) @(negedge clk);
        check_value("full_receive_count", 64'(3 + `PN_LEN + 6),
                    64'(word_count - base - `META_WORDS));
        verify_packet("full_receive", base);
    endtask

    task automatic transmit_pattern();
        int base;
        int det0;
        int pulses0;
        base = word_count;
        det0 = det_clocks;
        pulses0 = pulse_count;
        run_packet(6);
        wait_words(base + exp_soft.size() + `META_WORDS);
        check_value("tx_pattern_word", 64'(i_tx_word), 64'(tx_seen));
        check_value("tx_pattern_pulses", 64'(`TX_BITS), 64'(pulse_count - pulses0));
        check_value("tx_pattern_detector", 64'(`TX_BITS * SYM_CLOCKS + `HOLDOFF_CYCLES * SPC),
                    64'(det_clocks - det0));
        check_value("tx_pattern_stray", 64'd0, 64'(bad_pulse));
    endtask

    task automatic transmit_disabled();
        int base;
        int pulses0;
        int en0;
        base = word_count;
        pulses0 = pulse_count;
        en0 = tx_en_clocks;
        i_tx_disable = 1'b1;
        run_packet(6);
        wait_words(base + exp_soft.size() + `META_WORDS);
        i_tx_disable = 1'b0;
        check_value("tx_disabled_pulses", 64'd0, 64'(pulse_count - pulses0));
        check_value("tx_disabled_en", 64'd0, 64'(tx_en_clocks - en0));
        verify_packet("tx_disabled", base);
    endtask

    task automatic credit_backpressure();
        int base;
        base = word_count;
        credit_limit = credit_sent;
        exp_soft.delete();
        fork
            run_packet(6);
            begin
                // Credits come back part way through the packet, before the queue fills
                while (exp_soft.size() < STALL_BITS) begin
                    @(negedge clk);
                end
                check_value("credit_stalled", 64'(`INIT_CREDITS), 64'(word_count - base));
                credit_limit = BIG_LIMIT;
            end
        join
        wait_words(base + exp_soft.size() + `META_WORDS);
        repeat (20) @(negedge clk);
        check_value("credit_total", 64'(exp_soft.size() + `META_WORDS), 64'(word_count - base));
        check_value("credit_overflow", 64'd0, 64'(o_overflow));
        verify_packet("credit", base);
    endtask

    task automatic overflow_when_stalled();
        int base;
        base = word_count;
        credit_limit = credit_sent;
        check_value("overflow_before", 64'd0, 64'(o_overflow));
        run_packet(10);
        check_value("overflow_set", 64'd1, 64'(o_overflow));
        credit_limit = BIG_LIMIT;
        wait_words(base + `QUEUE_DEPTH + `INIT_CREDITS);
    endtask

    // Watchdog sized from the packet lengths with a factor of two margin
    initial begin
        int limit_ns;
        limit_ns = 2 * 10 * (4 * packet_clocks(6) + packet_clocks(10) + 500);
        #(limit_ns);
        $display("Timeout: the DUT did not finish the tests in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        repeat (10) @(negedge clk);
        rst = 1'b0;
        i_sample_valid = 1'b1;
        idle_after_reset();
        full_receive();
        transmit_pattern();
        transmit_disabled();
        credit_backpressure();
        overflow_when_stalled();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
loopback_pkg.sv
cycle_timer.sv
bit_energy.sv
pn_search.sv
decoded_out.sv
loopback_ctrl.sv
mrr_loopback.sv
tb_mrr_loopback.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing -f sources.f --top-module tb_mrr_loopback -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/Vtb_mrr_loopback); echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
